// ==== rtl/disc_params.svh ====
// sizing of the discriminator datapath, shared by the RTL and the testbench
// start and stop delays above DISC_MAX_DELAY batches cannot be programmed
// the timestamp counter wraps silently after 2**DISC_TSTAMP_WIDTH batches

`ifndef DISC_PARAMS_SVH
`define DISC_PARAMS_SVH

`define DISC_SAMPLE_WIDTH 16      // bits per signed sample
`define DISC_PARALLEL_SAMPLES 4   // samples per batch
`define DISC_MAX_DELAY 15         // longest start or stop delay, in batches
`define DISC_TSTAMP_WIDTH 32      // batch index width

`endif

// ==== rtl/disc_pkg.sv ====
// types shared by the discriminator blocks
// sample 0 of a batch sits in the low bits and is the earliest in time

`default_nettype none

`include "disc_params.svh"

package disc_pkg;

  // one signed ADC sample
  typedef logic signed [`DISC_SAMPLE_WIDTH-1:0] sample_t;

  // samples of one adc_clk cycle
  typedef sample_t [`DISC_PARALLEL_SAMPLES-1:0] batch_t;

  // delay in batches, sized for DISC_MAX_DELAY
  typedef logic [$clog2(`DISC_MAX_DELAY + 1)-1:0] delay_t;

  // index of a valid batch since the last configuration load
  typedef logic [`DISC_TSTAMP_WIDTH-1:0] tstamp_t;

  typedef enum logic [1:0] {
    DISC_FILL,  // history not yet deep enough after a load
    DISC_IDLE,  // last decided batch was dropped
    DISC_KEEP   // last decided batch was kept
  } disc_state_e;

endpackage

`default_nettype wire

// ==== rtl/threshold_detector.sv ====
// compares every valid batch against the low and high thresholds
// thresholds are signed and only change on cfg_load_i
// flags come out one cycle after the batch, qualified by det_valid_o

`default_nettype none

`include "disc_params.svh"

module threshold_detector (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  logic              cfg_load_i,
  input  disc_pkg::sample_t low_threshold_i,
  input  disc_pkg::sample_t high_threshold_i,
  input  logic              adc_valid_i,
  input  disc_pkg::batch_t  adc_batch_i,
  output logic              above_high_o,
  output logic              above_low_o,
  output logic              det_valid_o
);
  import disc_pkg::*;

  sample_t low_q;
  sample_t high_q;
  logic [`DISC_PARALLEL_SAMPLES-1:0] hi_hit;
  logic [`DISC_PARALLEL_SAMPLES-1:0] lo_hit;

  // all samples of the batch side by side, signed compare
  always_comb begin
    for (int k = 0; k < `DISC_PARALLEL_SAMPLES; k++) begin
      hi_hit[k] = sample_t'(adc_batch_i[k]) > high_q;
      lo_hit[k] = sample_t'(adc_batch_i[k]) > low_q;
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      low_q       <= '0;
      high_q      <= '0;
      det_valid_o <= 1'b0;
    end else begin
      if (cfg_load_i) begin
        low_q  <= low_threshold_i;
        high_q <= high_threshold_i;
      end
      det_valid_o <= adc_valid_i;
    end
  end

  always_ff @(posedge adc_clk) begin
    above_high_o <= |hi_hit;  // any sample over high
    above_low_o  <= |lo_hit;
  end

endmodule

`default_nettype wire

// ==== rtl/pretrigger_buffer.sv ====
// batch history that lines the pre-trigger samples up with the keep decision
// keep_i for a batch arrives two cycles after that batch entered, and one
// more valid batch may have been shifted in between; valid_q accounts for it

`default_nettype none

`include "disc_params.svh"

module pretrigger_buffer (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  logic              adc_valid_i,
  input  disc_pkg::batch_t  adc_batch_i,
  input  disc_pkg::delay_t  start_delay_i,
  input  logic              keep_i,
  output logic              data_valid_o,
  output disc_pkg::batch_t  data_o
);
  import disc_pkg::*;

  localparam int DEPTH = `DISC_MAX_DELAY + 2;
  localparam int TAP_W = $clog2(DEPTH);

  batch_t hist_q [DEPTH];
  logic valid_q;  // batch accepted on the previous edge
  logic [TAP_W-1:0] tap;

  // the batch the controller just decided on sits at start_delay_i + valid_q
  assign tap = TAP_W'(start_delay_i) + TAP_W'(valid_q);

  always_ff @(posedge adc_clk) begin
    if (adc_valid_i) begin
      hist_q[0] <= adc_batch_i;
      for (int k = 1; k < DEPTH; k++) begin
        hist_q[k] <= hist_q[k-1];
      end
    end
    if (keep_i) begin
      data_o <= hist_q[tap];
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q      <= 1'b0;
      data_valid_o <= 1'b0;
    end else begin
      valid_q      <= adc_valid_i;
      data_valid_o <= keep_i;  // one pulse per kept batch
    end
  end

endmodule

`default_nettype wire

// ==== rtl/timestamp_counter.sv ====
// counts valid batches since clear_i and stamps the first batch of each run
// the stamp is the index of the batch at the buffer tap, not the trigger batch

`default_nettype none

`include "disc_params.svh"

module timestamp_counter (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  logic              clear_i,
  input  logic              adc_valid_i,
  input  disc_pkg::delay_t  start_delay_i,
  input  logic              run_start_i,
  output logic              tstamp_valid_o,
  output disc_pkg::tstamp_t tstamp_o
);
  import disc_pkg::*;

  tstamp_t count_q;
  logic valid_q;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q        <= '0;
      valid_q        <= 1'b0;
      tstamp_valid_o <= 1'b0;
    end else begin
      if (clear_i) begin
        count_q <= tstamp_t'(adc_valid_i);  // a batch may land on the clear cycle
      end else begin
        count_q <= count_q + tstamp_t'(adc_valid_i);
      end
      valid_q        <= adc_valid_i;
      tstamp_valid_o <= run_start_i;  // same edge as data_valid_o
    end
  end

  // count holds one batch more than the decided one, plus any that followed it
  always_ff @(posedge adc_clk) begin
    if (run_start_i) begin
      tstamp_o <= count_q - tstamp_t'(1) - tstamp_t'(valid_q) - tstamp_t'(start_delay_i);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/discriminator_ctrl.sv ====
// hysteresis trigger, fill window and hold countdown deciding kept batches
// one decision per det_valid_i, for the batch start_delay batches older
// delays take effect on cfg_load_i only, and a load restarts the fill window

`default_nettype none

`include "disc_params.svh"

module discriminator_ctrl (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  logic             cfg_load_i,
  input  disc_pkg::delay_t start_delay_i,
  input  disc_pkg::delay_t stop_delay_i,
  input  logic             disable_i,
  input  logic             det_valid_i,
  input  logic             above_high_i,
  input  logic             above_low_i,
  output disc_pkg::delay_t start_delay_o,
  output logic             clear_o,
  output logic             keep_o,
  output logic             run_start_o
);
  import disc_pkg::*;

  // countdown has to reach start_delay + stop_delay
  localparam int HOLD_W = $clog2(2 * `DISC_MAX_DELAY + 1);

  disc_state_e state_q;
  delay_t start_delay_q;
  delay_t stop_delay_q;
  delay_t fill_cnt_q;
  logic [HOLD_W-1:0] hold_q;
  logic trigger_q;

  logic filled;
  logic step;
  logic trigger_d;
  logic keep_d;

  assign filled = (fill_cnt_q == start_delay_q);

  // the batch that completes the fill is already a real decision
  assign step = det_valid_i & ((state_q != DISC_FILL) | filled);

  // on above high, off once nothing clears low
  assign trigger_d = above_low_i & (above_high_i | trigger_q);

  assign keep_d = disable_i | trigger_d | (hold_q != '0);

  assign start_delay_o = start_delay_q;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q       <= DISC_FILL;
      start_delay_q <= '0;
      stop_delay_q  <= '0;
      fill_cnt_q    <= '0;
      hold_q        <= '0;
      trigger_q     <= 1'b0;
      clear_o       <= 1'b0;
      keep_o        <= 1'b0;
      run_start_o   <= 1'b0;
    end else begin
      clear_o     <= cfg_load_i;
      keep_o      <= 1'b0;
      run_start_o <= 1'b0;
      if (cfg_load_i) begin
        start_delay_q <= start_delay_i;
        stop_delay_q  <= stop_delay_i;
        fill_cnt_q    <= '0;
        hold_q        <= '0;
        trigger_q     <= 1'b0;
        state_q       <= DISC_FILL;
      end else if (step) begin
        trigger_q <= trigger_d;
        if (trigger_d) begin
          // window reaches stop_delay past the tap of the trigger batch
          hold_q <= HOLD_W'(start_delay_q) + HOLD_W'(stop_delay_q);
        end else if (hold_q != '0) begin
          hold_q <= hold_q - 1'b1;
        end
        keep_o <= keep_d;
        // new run only when the previous decision dropped its batch
        run_start_o <= keep_d & ~disable_i & (state_q != DISC_KEEP);
        state_q <= keep_d ? DISC_KEEP : DISC_IDLE;
      end else if (state_q == DISC_FILL) begin
        if (filled) begin
          state_q <= DISC_IDLE;
        end else if (det_valid_i) begin
          fill_cnt_q <= fill_cnt_q + 1'b1;  // triggers here are ignored
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sample_discriminator.sv ====
// single-channel discriminator for a realtime ADC batch stream
// no back-pressure; load configuration only while adc_valid_i is low
// kept batches leave start_delay + 3 cycles after entry on a gapless stream

`default_nettype none

`include "disc_params.svh"

module sample_discriminator (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  logic              adc_valid_i,
  input  disc_pkg::batch_t  adc_batch_i,
  input  logic              cfg_load_i,
  input  disc_pkg::sample_t low_threshold_i,
  input  disc_pkg::sample_t high_threshold_i,
  input  disc_pkg::delay_t  start_delay_i,
  input  disc_pkg::delay_t  stop_delay_i,
  input  logic              disable_i,
  output logic              data_valid_o,
  output disc_pkg::batch_t  data_o,
  output logic              tstamp_valid_o,
  output disc_pkg::tstamp_t tstamp_o
);
  import disc_pkg::*;

  logic above_high;
  logic above_low;
  logic det_valid;
  logic keep;
  logic run_start;
  logic clear;
  delay_t start_delay;  // latched copy from the controller

  threshold_detector u_threshold_detector (
    .adc_clk          (adc_clk),
    .rst_n_i          (rst_n_i),
    .cfg_load_i       (cfg_load_i),
    .low_threshold_i  (low_threshold_i),
    .high_threshold_i (high_threshold_i),
    .adc_valid_i      (adc_valid_i),
    .adc_batch_i      (adc_batch_i),
    .above_high_o     (above_high),
    .above_low_o      (above_low),
    .det_valid_o      (det_valid)
  );

  discriminator_ctrl u_discriminator_ctrl (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n_i),
    .cfg_load_i    (cfg_load_i),
    .start_delay_i (start_delay_i),
    .stop_delay_i  (stop_delay_i),
    .disable_i     (disable_i),
    .det_valid_i   (det_valid),
    .above_high_i  (above_high),
    .above_low_i   (above_low),
    .start_delay_o (start_delay),
    .clear_o       (clear),
    .keep_o        (keep),
    .run_start_o   (run_start)
  );

  pretrigger_buffer u_pretrigger_buffer (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n_i),
    .adc_valid_i   (adc_valid_i),
    .adc_batch_i   (adc_batch_i),
    .start_delay_i (start_delay),
    .keep_i        (keep),
    .data_valid_o  (data_valid_o),
    .data_o        (data_o)
  );

  timestamp_counter u_timestamp_counter (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .clear_i        (clear),
    .adc_valid_i    (adc_valid_i),
    .start_delay_i  (start_delay),
    .run_start_i    (run_start),
    .tstamp_valid_o (tstamp_valid_o),
    .tstamp_o       (tstamp_o)
  );

endmodule

`default_nettype wire

// ==== tests/disc_ref_model.svh ====
// expected output of the discriminator for one configuration and one stream
// included inside the testbench module, after the disc_pkg import
// reads sent_q and sent_idx_q, rebuilds exp_batch_q and exp_ts_q

`ifndef DISC_REF_MODEL_SVH
`define DISC_REF_MODEL_SVH

// one decision per valid batch j >= start_delay, for the batch start_delay older
function automatic void model_kept(input sample_t low, input sample_t high,
                                   input delay_t sd, input delay_t st, input logic dis);
  logic trig;
  logic trig_next;
  logic any_low;
  logic any_high;
  logic keep;
  logic kept_prev;
  int hold;
  int tap;
  trig = 1'b0;
  hold = 0;
  kept_prev = 1'b0;  // nothing decided yet after the load
  exp_batch_q.delete();
  exp_ts_q.delete();
  for (int j = int'(sd); j < sent_q.size(); j++) begin
    any_low = 1'b0;
    any_high = 1'b0;
    for (int k = 0; k < `DISC_PARALLEL_SAMPLES; k++) begin
      if (sample_t'(sent_q[j][k]) > low) any_low = 1'b1;
      if (sample_t'(sent_q[j][k]) > high) any_high = 1'b1;
    end
    // hysteresis: on above high, held while anything is above low
    trig_next = any_high | (trig & any_low);
    keep = dis | trig_next | (hold != 0);
    if (trig_next) begin
      hold = int'(sd) + int'(st);
    end else if (hold != 0) begin
      hold = hold - 1;
    end
    trig = trig_next;
    tap = j - int'(sd);
    if (keep) begin
      exp_batch_q.push_back(sent_q[tap]);
      if (!dis && !kept_prev) begin
        exp_ts_q.push_back(sent_idx_q[tap]);  // first batch of a run
      end
    end
    kept_prev = keep;
  end
endfunction

`endif

// ==== tests/tb_sample_discriminator.sv ====
// drives the discriminator with ramp, spike and random streams and checks them against model_kept
// configuration is loaded only between streams while adc_valid_i is low
// the last start_delay batches of a stream are never decided and never leave

`default_nettype none

`include "disc_params.svh"

module tb_sample_discriminator;
  timeunit 1ns;
  timeprecision 1ps;
  import disc_pkg::*;

  localparam int RAMP_LEN = 40;
  localparam int RAND_LEN = 200;
  localparam int TS_LEN = 60;
  localparam int DIS_LEN = 50;
  localparam int FILL_LEN = 20;
  localparam int NUM_RUNS = 7;
  localparam int DRAIN_CYCLES = 6;  // last output comes 3 cycles after the last batch
  localparam int TIMEOUT_CYCLES = 8 + RAMP_LEN + 5 * RAND_LEN + TS_LEN + DIS_LEN
                                  + 2 * FILL_LEN + NUM_RUNS * (2 * `DISC_MAX_DELAY + 10);

  logic adc_clk = 1'b0;
  logic rst_n_i;
  logic adc_valid_i;
  batch_t adc_batch_i;
  logic cfg_load_i;
  sample_t low_threshold_i;
  sample_t high_threshold_i;
  delay_t start_delay_i;
  delay_t stop_delay_i;
  logic disable_i;
  logic data_valid_o;
  batch_t data_o;
  logic tstamp_valid_o;
  tstamp_t tstamp_o;

  integer seed = 32'hdaea;
  int cycle_cnt = 0;
  int err_cnt = 0;
  int tests_run = 0;
  int tests_failed = 0;

  batch_t stim_q[$];
  batch_t rand_q[$];
  batch_t sent_q[$];
  tstamp_t sent_idx_q[$];
  batch_t got_batch_q[$];
  tstamp_t got_ts_q[$];
  batch_t exp_batch_q[$];
  tstamp_t exp_ts_q[$];

  `include "disc_ref_model.svh"

  sample_discriminator u_sample_discriminator (
    .adc_clk          (adc_clk),
    .rst_n_i          (rst_n_i),
    .adc_valid_i      (adc_valid_i),
    .adc_batch_i      (adc_batch_i),
    .cfg_load_i       (cfg_load_i),
    .low_threshold_i  (low_threshold_i),
    .high_threshold_i (high_threshold_i),
    .start_delay_i    (start_delay_i),
    .stop_delay_i     (stop_delay_i),
    .disable_i        (disable_i),
    .data_valid_o     (data_valid_o),
    .data_o           (data_o),
    .tstamp_valid_o   (tstamp_valid_o),
    .tstamp_o         (tstamp_o)
  );

  always #50 adc_clk = ~adc_clk;

  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", cycle_cnt);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // outputs change on the rising edge and are taken on the falling one
  always @(negedge adc_clk) begin
    if (data_valid_o) got_batch_q.push_back(data_o);
    if (tstamp_valid_o) got_ts_q.push_back(tstamp_o);
    if (tstamp_valid_o && !data_valid_o) begin
      $display("a timestamp at %0t came without a kept batch in the same cycle", $time);
      err_cnt++;
    end
  end

  // noise of about +-1200 with an occasional spike on one sample
  function automatic batch_t rand_batch();
    batch_t b;
    for (int k = 0; k < `DISC_PARALLEL_SAMPLES; k++) begin
      b[k] = sample_t'($random(seed) % 1200);
    end
    if (($random(seed) & 15) == 0) begin
      b[$unsigned($random(seed)) % `DISC_PARALLEL_SAMPLES] = sample_t'(6000);
    end
    return b;
  endfunction

  function automatic batch_t flat_batch(input int v);
    batch_t b;
    for (int k = 0; k < `DISC_PARALLEL_SAMPLES; k++) begin
      b[k] = sample_t'(v - 3 * k);  // slight slope inside the batch
    end
    return b;
  endfunction

  task automatic check_batch(input string sig, input int idx, input batch_t exp,
                             input batch_t act);
    if (exp !== act) begin
      $display("ERROR %0t %s[%0d] expected %h actual %h", $time, sig, idx, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_tstamp(input string sig, input int idx, input tstamp_t exp,
                              input tstamp_t act);
    if (exp !== act) begin
      $display("ERROR %0t %s[%0d] expected %0d actual %0d", $time, sig, idx, exp, act);
      err_cnt++;
    end
  endtask

  task automatic compare_results(input string what);
    if (got_batch_q.size() != exp_batch_q.size()) begin
      $display("%s: expected %0d kept batches, data_o gave %0d", what,
               exp_batch_q.size(), got_batch_q.size());
      err_cnt++;
    end
    if (got_ts_q.size() != exp_ts_q.size()) begin
      $display("%s: expected %0d timestamps, tstamp_o gave %0d", what,
               exp_ts_q.size(), got_ts_q.size());
      err_cnt++;
    end
    for (int n = 0; n < exp_batch_q.size() && n < got_batch_q.size(); n++) begin
      check_batch("data_o", n, exp_batch_q[n], got_batch_q[n]);
    end
    for (int n = 0; n < exp_ts_q.size() && n < got_ts_q.size(); n++) begin
      check_tstamp("tstamp_o", n, exp_ts_q[n], got_ts_q[n]);
    end
  endtask

  task automatic load_cfg(input sample_t low, input sample_t high, input delay_t sd,
                          input delay_t st, input logic dis);
    @(posedge adc_clk);
    cfg_load_i       <= 1'b1;
    low_threshold_i  <= low;
    high_threshold_i <= high;
    start_delay_i    <= sd;
    stop_delay_i     <= st;
    disable_i        <= dis;
    @(posedge adc_clk);
    cfg_load_i <= 1'b0;
    sent_q.delete();
    sent_idx_q.delete();
    got_batch_q.delete();
    got_ts_q.delete();
  endtask

  task automatic run_stream(input sample_t low, input sample_t high, input delay_t sd,
                            input delay_t st, input logic dis, input logic gaps);
    int idle;
    load_cfg(low, high, sd, st, dis);
    for (int n = 0; n < stim_q.size(); n++) begin
      idle = gaps ? ($unsigned($random(seed)) % 4) : 0;
      repeat (idle) begin
        @(posedge adc_clk);
        adc_valid_i <= 1'b0;
        adc_batch_i <= rand_batch();  // junk that must be ignored
      end
      @(posedge adc_clk);
      adc_valid_i <= 1'b1;
      adc_batch_i <= stim_q[n];
      sent_q.push_back(stim_q[n]);
      sent_idx_q.push_back(tstamp_t'(n));
    end
    @(posedge adc_clk);
    adc_valid_i <= 1'b0;
    repeat (DRAIN_CYCLES) @(posedge adc_clk);
    model_kept(low, high, sd, st, dis);
    compare_results("model");
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt != errs_before) tests_failed++;
    $display("test %-16s %s  (%0d batches, %0d timestamps)", name,
             (err_cnt == errs_before) ? "ok" : "mismatch", got_batch_q.size(), got_ts_q.size());
  endtask

  initial begin
    int errs_before;
    rst_n_i          = 1'b0;
    adc_valid_i      = 1'b0;
    adc_batch_i      = '0;
    cfg_load_i       = 1'b0;
    low_threshold_i  = '0;
    high_threshold_i = '0;
    start_delay_i    = '0;
    stop_delay_i     = '0;
    disable_i        = 1'b0;
    repeat (8) @(posedge adc_clk);
    rst_n_i <= 1'b1;

    // ramp over high, lingers between thresholds, then drops below low
    stim_q.delete();
    for (int n = 0; n < RAMP_LEN; n++) begin
      stim_q.push_back(flat_batch(n < 10 ? n * 150 : (n < 25 ? 500 : 20)));
    end
    errs_before = err_cnt;
    run_stream(16'sd100, 16'sd1000, 4'd0, 4'd0, 1'b0, 1'b0);
    report_test("hysteresis", errs_before);

    for (int n = 0; n < RAND_LEN; n++) begin
      rand_q.push_back(rand_batch());
    end
    stim_q = rand_q;
    errs_before = err_cnt;
    run_stream(16'sd1000, 16'sd4000, 4'd3, 4'd5, 1'b0, 1'b0);
    report_test("windows", errs_before);

    // spikes at 20 and 22 merge into one run
    stim_q.delete();
    for (int n = 0; n < TS_LEN; n++) begin
      stim_q.push_back(flat_batch((n == 10 || n == 20 || n == 22 || n == 45) ? 5000 : 0));
    end
    errs_before = err_cnt;
    run_stream(16'sd200, 16'sd3000, 4'd2, 4'd1, 1'b0, 1'b0);
    report_test("timestamps", errs_before);

    // same random stream and configuration as the windows test, so the same expectation
    stim_q = rand_q;
    errs_before = err_cnt;
    run_stream(16'sd1000, 16'sd4000, 4'd3, 4'd5, 1'b0, 1'b1);
    report_test("gaps in valid", errs_before);

    stim_q.delete();
    for (int n = 0; n < DIS_LEN; n++) begin
      stim_q.push_back(rand_batch());
    end
    errs_before = err_cnt;
    run_stream(16'sd1000, 16'sd4000, 4'd4, 4'd2, 1'b1, 1'b0);
    report_test("disable", errs_before);

    stim_q.delete();
    for (int n = 0; n < FILL_LEN; n++) begin
      stim_q.push_back(flat_batch(n == 2 ? 5000 : 0));
    end
    errs_before = err_cnt;
    run_stream(16'sd100, 16'sd1000, 4'd6, 4'd2, 1'b0, 1'b0);
    if (got_batch_q.size() != 0 || got_ts_q.size() != 0) begin
      $display("fill window: a trigger inside the fill window produced output");
      err_cnt++;
    end
    report_test("fill window", errs_before);

    // same spike later and the index counts again from zero
    stim_q.delete();
    for (int n = 0; n < FILL_LEN; n++) begin
      stim_q.push_back(flat_batch(n == 8 ? 5000 : 0));
    end
    errs_before = err_cnt;
    run_stream(16'sd100, 16'sd1000, 4'd6, 4'd2, 1'b0, 1'b0);
    report_test("reload", errs_before);

    $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+rtl
+incdir+tests
rtl/disc_pkg.sv
rtl/threshold_detector.sv
rtl/pretrigger_buffer.sv
rtl/timestamp_counter.sv
rtl/discriminator_ctrl.sv
rtl/sample_discriminator.sv
tests/tb_sample_discriminator.sv

// ==== Bender.yml ====
package:
  name: sample_discriminator

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/disc_pkg.sv
      - rtl/threshold_detector.sv
      - rtl/pretrigger_buffer.sv
      - rtl/timestamp_counter.sv
      - rtl/discriminator_ctrl.sv
      - rtl/sample_discriminator.sv
  - target: test
    include_dirs:
      - rtl
      - tests
    files:
      - tests/tb_sample_discriminator.sv
